// File: tb.f
+incdir+.
exu_pkg.sv
exu_regfile.sv
exu_alu.sv
exu_bru.sv
exu_ecl.sv
cpu_exu.sv
exu_chk.sv
tb_exu.sv

// File: Bender.yml
package:
  name: cpu_exu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - exu_regfile.sv
      - exu_alu.sv
      - exu_bru.sv
      - exu_ecl.sv
      - cpu_exu.sv
  - target: test
    include_dirs:
      - .
    files:
      - exu_chk.sv
      - tb_exu.sv

// File: tb_exu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module tb_exu import exu_pkg::*; ();

   localparam int N_INSTR    = 2000;
   localparam int MAX_CYCLES = N_INSTR + N_INSTR / 2;   // idle slots plus drain

   logic                 clk;
   logic                 reset;
   logic                 valid_d;
   logic [`EXU_XLEN-1:0] pc_d;
   inst_word_t           inst_d;
   exu_op_t              op_d;
   logic                 br_taken_e;
   logic [`EXU_XLEN-1:0] brpc_e;
   logic                 wb_valid;
   logic [`EXU_XLEN-1:0] wb_pc;
   logic [`EXU_RAW-1:0]  wb_rd;
   logic [`EXU_XLEN-1:0] wb_data;

   logic [`EXU_XLEN-1:0] model_regs [`EXU_NREG];
   logic [`EXU_XLEN-1:0] model_pc;
   logic                 last_taken;   // previous slot held a taken branch
   logic [`EXU_XLEN-1:0] exp_pc_q [$];
   logic [`EXU_RAW-1:0]  exp_rd_q [$];
   logic [`EXU_XLEN-1:0] exp_data_q [$];

   logic                 br_next;      // for the instruction now in d
   logic [`EXU_XLEN-1:0] brpc_next;
   logic                 br_exp;       // for the instruction now in e
   logic [`EXU_XLEN-1:0] brpc_exp;

   integer seed;
   int     errors;
   int     checks;
   int     cycles;
   int     issued;
   int     annulled;
   int     commits;

   cpu_exu uut (
      .clk        (clk        ),
      .reset      (reset      ),
      .valid_d    (valid_d    ),
      .pc_d       (pc_d       ),
      .inst_d     (inst_d     ),
      .op_d       (op_d       ),
      .br_taken_e (br_taken_e ),
      .brpc_e     (brpc_e     ),
      .wb_valid   (wb_valid   ),
      .wb_pc      (wb_pc      ),
      .wb_rd      (wb_rd      ),
      .wb_data    (wb_data    )
   );

   always #5 clk = ~clk;

   function automatic logic [`EXU_XLEN-1:0] ref_result(
      exu_op_t op, logic [`EXU_XLEN-1:0] a, logic [`EXU_XLEN-1:0] b, logic [11:0] imm);
      logic [`EXU_XLEN-1:0] simm;
      logic [`EXU_XLEN-1:0] zimm;
      simm = {{(`EXU_XLEN-12){imm[11]}}, imm};
      zimm = {{(`EXU_XLEN-12){1'b0}}, imm};
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? `EXU_XLEN'd1 : `EXU_XLEN'd0;
         OP_SLTU: return (a < b) ? `EXU_XLEN'd1 : `EXU_XLEN'd0;
         OP_SLL:  return a << b[4:0];
         OP_SRL:  return a >> b[4:0];
         OP_ADDI: return a + simm;
         OP_ANDI: return a & zimm;
         OP_ORI:  return a | zimm;
         default: return '0;
      endcase
   endfunction

   function automatic logic ref_taken(exu_op_t op, logic [`EXU_XLEN-1:0] a,
                                      logic [`EXU_XLEN-1:0] b);
      case (op)
         OP_BEQ:  return a == b;
         OP_BNE:  return a != b;
         OP_BLT:  return $signed(a) < $signed(b);
         OP_BLTU: return a < b;
         default: return 1'b0;
      endcase
   endfunction

   // one stimulus slot, executed on the model in issue order
   task automatic drive_slot();
      logic [31:0]          rnd;
      inst_word_t           w;
      exu_op_t              op;
      logic [`EXU_XLEN-1:0] a;
      logic [`EXU_XLEN-1:0] b;
      logic [`EXU_XLEN-1:0] res;
      logic                 cond;
      br_next   = 1'b0;
      brpc_next = '0;
      rnd = $random(seed);
      w   = $random(seed);
      op  = exu_op_t'(rnd[7:4]);
      if (rnd[2:0] == 3'd0) begin
         valid_d    = 1'b0;   // idle, junk on the other inputs
         inst_d     = w;
         op_d       = op;
         last_taken = 1'b0;
      end else begin
         w.r3.rd = {2'b00, rnd[10:8]};   // small register range for dependencies
         w.r3.rj = {2'b00, rnd[13:11]};
         if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
                        OP_SLL, OP_SRL}) begin
            w.r3.rk = {2'b00, rnd[16:14]};
         end
         valid_d  = 1'b1;
         pc_d     = model_pc;
         inst_d   = w;
         op_d     = op;
         model_pc = model_pc + 4;
         issued++;
         if (last_taken) begin
            annulled++;
            last_taken = 1'b0;
         end else if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BLTU}) begin
            a    = model_regs[w.ri16.rj];
            b    = model_regs[w.ri16.rd];
            cond = ref_taken(op, a, b);
            br_next    = cond;
            brpc_next  = pc_d + ({{(`EXU_XLEN-16){w.ri16.offs16[15]}}, w.ri16.offs16} << 2);
            last_taken = cond;
         end else begin
            a   = model_regs[w.r3.rj];
            b   = model_regs[w.r3.rk];
            res = ref_result(op, a, b, w.ri12.imm12);
            if (w.r3.rd != '0) begin
               model_regs[w.r3.rd] = res;
               exp_pc_q.push_back(pc_d);
               exp_rd_q.push_back(w.r3.rd);
               exp_data_q.push_back(res);
            end
         end
      end
   endtask

   always @(posedge clk) begin
      br_exp   <= br_next;
      brpc_exp <= brpc_next;
   end

   // compare at mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         checks++;
         if (br_taken_e !== br_exp) begin
            $display("Mismatch at %0t: br_taken_e expected %b got %b", $time, br_exp, br_taken_e);
            errors++;
         end else if (br_exp && brpc_e !== brpc_exp) begin
            $display("Mismatch at %0t: brpc_e expected %h got %h", $time, brpc_exp, brpc_e);
            errors++;
         end
         if (wb_valid === 1'b1) begin
            if (exp_pc_q.size() == 0) begin
               $display("Unexpected commit at %0t: no instruction was due to write back", $time);
               errors++;
            end else begin
               commits++;
               if (wb_pc !== exp_pc_q[0]) begin
                  $display("Mismatch at %0t: wb_pc expected %h got %h", $time, exp_pc_q[0], wb_pc);
                  errors++;
               end
               if (wb_rd !== exp_rd_q[0]) begin
                  $display("Mismatch at %0t: wb_rd expected %0d got %0d", $time, exp_rd_q[0],
                           wb_rd);
                  errors++;
               end
               if (wb_data !== exp_data_q[0]) begin
                  $display("Mismatch at %0t: wb_data expected %h got %h", $time, exp_data_q[0],
                           wb_data);
                  errors++;
               end
               void'(exp_pc_q.pop_front());
               void'(exp_rd_q.pop_front());
               void'(exp_data_q.pop_front());
            end
         end else if (wb_valid !== 1'b0) begin
            $display("Mismatch at %0t: wb_valid expected 0 got %b", $time, wb_valid);
            errors++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, %0d commits still outstanding", cycles,
                  exp_pc_q.size());
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      int fails;
      seed       = 32'hc1c73293;
      clk        = 1'b0;
      reset      = 1'b1;
      valid_d    = 1'b0;
      pc_d       = '0;
      inst_d     = '0;
      op_d       = OP_ADD;
      br_next    = 1'b0;
      brpc_next  = '0;
      model_pc   = 32'h1c00_0000;
      last_taken = 1'b0;
      errors     = 0;
      checks     = 0;
      cycles     = 0;
      issued     = 0;
      annulled   = 0;
      commits    = 0;
      for (int i = 0; i < `EXU_NREG; i++) begin
         model_regs[i] = '0;
      end
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      while (issued < N_INSTR) begin
         drive_slot();
         @(posedge clk);
         #1;
      end
      valid_d   = 1'b0;
      br_next   = 1'b0;
      brpc_next = '0;
      while (exp_pc_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
      #1;   // after the last compare and assertion updates
      fails = uut.chk.fails;
      $display("issued %0d, annulled %0d, commits %0d, checks %0d, errors %0d, assertion fails %0d",
               issued, annulled, commits, checks, errors, fails);
      if (errors == 0 && fails == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: exu_chk.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_chk (
   input  logic                clk,
   input  logic                reset,
   input  logic                br_taken_e,
   input  logic                wb_valid,
   input  logic [`EXU_RAW-1:0] wb_rd
);

   int unsigned fails = 0;   // failed assertion count

   wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != '0)
      else begin
         fails++;
         $error("commit trace shows a write to r0");
      end

   // first cycle out of reset
   br_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !br_taken_e)
      else begin
         fails++;
         $error("branch taken right after reset");
      end

   br_single_cycle: assert property (@(posedge clk) disable iff (reset) br_taken_e |=> !br_taken_e)
      else begin
         fails++;
         $error("branch taken on two cycles in a row");
      end

endmodule

bind cpu_exu exu_chk chk (
   .clk        (clk        ),
   .reset      (reset      ),
   .br_taken_e (br_taken_e ),
   .wb_valid   (wb_valid   ),
   .wb_rd      (wb_rd      )
);

// File: cpu_exu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module cpu_exu import exu_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 valid_d,
   input  logic [`EXU_XLEN-1:0] pc_d,
   input  inst_word_t           inst_d,
   input  exu_op_t              op_d,

   output logic                 br_taken_e,
   output logic [`EXU_XLEN-1:0] brpc_e,

   output logic                 wb_valid,
   output logic [`EXU_XLEN-1:0] wb_pc,
   output logic [`EXU_RAW-1:0]  wb_rd,
   output logic [`EXU_XLEN-1:0] wb_data
);

   logic [`EXU_RAW-1:0]  rf_raddr0;
   logic [`EXU_RAW-1:0]  rf_raddr1;
   logic [`EXU_XLEN-1:0] rf_rdata0;
   logic [`EXU_XLEN-1:0] rf_rdata1;
   logic                 rf_wen;
   logic [`EXU_RAW-1:0]  rf_waddr;
   logic [`EXU_XLEN-1:0] rf_wdata;

   logic                 valid_e;
   logic [`EXU_XLEN-1:0] alu_a_e;
   logic [`EXU_XLEN-1:0] alu_b_e;
   exu_op_t              op_e;
   logic [`EXU_XLEN-1:0] pc_e;
   logic [`EXU_XLEN-1:0] offs_e;
   logic [`EXU_XLEN-1:0] alu_res_e;

   exu_regfile registers (
      .clk        (clk        ),
      .reset      (reset      ),
      .raddr0     (rf_raddr0  ),
      .raddr1     (rf_raddr1  ),
      .rdata0     (rf_rdata0  ),
      .rdata1     (rf_rdata1  ),
      .wen        (rf_wen     ),
      .waddr      (rf_waddr   ),
      .wdata      (rf_wdata   )
   );

   exu_ecl ecl (
      .clk        (clk        ),
      .reset      (reset      ),
      .valid_d    (valid_d    ),
      .pc_d       (pc_d       ),
      .inst_d     (inst_d     ),
      .op_d       (op_d       ),
      .rf_raddr0  (rf_raddr0  ),
      .rf_raddr1  (rf_raddr1  ),
      .rf_rdata0  (rf_rdata0  ),
      .rf_rdata1  (rf_rdata1  ),
      .rf_wen     (rf_wen     ),
      .rf_waddr   (rf_waddr   ),
      .rf_wdata   (rf_wdata   ),
      .valid_e    (valid_e    ),
      .alu_a_e    (alu_a_e    ),
      .alu_b_e    (alu_b_e    ),
      .op_e       (op_e       ),
      .pc_e       (pc_e       ),
      .offs_e     (offs_e     ),
      .alu_res_e  (alu_res_e  ),
      .br_taken_e (br_taken_e ),   // annuls the d slot
      .wb_valid   (wb_valid   ),
      .wb_pc      (wb_pc      ),
      .wb_rd      (wb_rd      ),
      .wb_data    (wb_data    )
   );

   exu_alu alu (
      .a          (alu_a_e    ),
      .b          (alu_b_e    ),
      .op         (op_e       ),
      .res        (alu_res_e  )
   );

   // branch operands share the alu operand registers
   exu_bru bru (
      .valid_e    (valid_e    ),
      .op         (op_e       ),
      .a          (alu_a_e    ),
      .b          (alu_b_e    ),
      .pc         (pc_e       ),
      .offs       (offs_e     ),
      .taken      (br_taken_e ),
      .target     (brpc_e     )
   );

endmodule

// File: exu_ecl.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_ecl import exu_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 valid_d,
   input  logic [`EXU_XLEN-1:0] pc_d,
   input  inst_word_t           inst_d,
   input  exu_op_t              op_d,

   output logic [`EXU_RAW-1:0]  rf_raddr0,
   output logic [`EXU_RAW-1:0]  rf_raddr1,
   input  logic [`EXU_XLEN-1:0] rf_rdata0,
   input  logic [`EXU_XLEN-1:0] rf_rdata1,
   output logic                 rf_wen,
   output logic [`EXU_RAW-1:0]  rf_waddr,
   output logic [`EXU_XLEN-1:0] rf_wdata,

   output logic                 valid_e,
   output logic [`EXU_XLEN-1:0] alu_a_e,
   output logic [`EXU_XLEN-1:0] alu_b_e,
   output exu_op_t              op_e,
   output logic [`EXU_XLEN-1:0] pc_e,
   output logic [`EXU_XLEN-1:0] offs_e,
   input  logic [`EXU_XLEN-1:0] alu_res_e,
   input  logic                 br_taken_e,

   output logic                 wb_valid,
   output logic [`EXU_XLEN-1:0] wb_pc,
   output logic [`EXU_RAW-1:0]  wb_rd,
   output logic [`EXU_XLEN-1:0] wb_data
);

   logic [`EXU_RAW-1:0]  rd_d;
   logic                 is_imm_d;
   logic [`EXU_XLEN-1:0] imm_d;
   logic [`EXU_XLEN-1:0] offs_d;
   logic [`EXU_XLEN-1:0] src0_d;
   logic [`EXU_XLEN-1:0] src1_d;
   logic [`EXU_RAW-1:0]  rd_e;
   logic                 wen_e;
   logic                 valid_w;
   logic [`EXU_XLEN-1:0] pc_w;
   logic [`EXU_RAW-1:0]  rd_w;
   logic [`EXU_XLEN-1:0] data_w;

   // field decode by instruction format
   always_comb begin
      rf_raddr0 = inst_d.r3.rj;
      rf_raddr1 = inst_d.r3.rk;
      rd_d      = inst_d.r3.rd;
      is_imm_d  = 1'b0;
      imm_d     = '0;
      case (op_d)
         OP_ADDI: begin
            rf_raddr1 = '0;
            is_imm_d  = 1'b1;
            imm_d     = {{(`EXU_XLEN-12){inst_d.ri12.imm12[11]}}, inst_d.ri12.imm12};
         end
         OP_ANDI, OP_ORI: begin
            rf_raddr1 = '0;
            is_imm_d  = 1'b1;
            imm_d     = {{(`EXU_XLEN-12){1'b0}}, inst_d.ri12.imm12};
         end
         OP_BEQ, OP_BNE, OP_BLT, OP_BLTU: begin
            rf_raddr1 = inst_d.ri16.rd;   // compared, not written
            rd_d      = '0;
         end
         default: ;
      endcase
   end

   assign offs_d = {{(`EXU_XLEN-16){inst_d.ri16.offs16[15]}}, inst_d.ri16.offs16};

   // bypass, e result over w value over register file
   assign src0_d = (valid_e && wen_e && rd_e == rf_raddr0) ? alu_res_e :
                   (valid_w && rd_w == rf_raddr0)          ? data_w    : rf_rdata0;
   assign src1_d = (valid_e && wen_e && rd_e == rf_raddr1) ? alu_res_e :
                   (valid_w && rd_w == rf_raddr1)          ? data_w    : rf_rdata1;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_e <= 1'b0;
         wen_e   <= 1'b0;
         op_e    <= OP_ADD;
         pc_e    <= '0;
         rd_e    <= '0;
         alu_a_e <= '0;
         alu_b_e <= '0;
         offs_e  <= '0;
         valid_w <= 1'b0;
         pc_w    <= '0;
         rd_w    <= '0;
         data_w  <= '0;
      end else begin
         valid_e <= valid_d & ~br_taken_e;   // kill slot behind a taken branch
         wen_e   <= (rd_d != '0);
         op_e    <= op_d;
         pc_e    <= pc_d;
         rd_e    <= rd_d;
         alu_a_e <= src0_d;
         alu_b_e <= is_imm_d ? imm_d : src1_d;
         offs_e  <= offs_d;
         valid_w <= valid_e & wen_e;
         pc_w    <= pc_e;
         rd_w    <= rd_e;
         data_w  <= alu_res_e;
      end
   end

   assign rf_wen   = valid_w;
   assign rf_waddr = rd_w;
   assign rf_wdata = data_w;

   // commit trace
   assign wb_valid = valid_w;
   assign wb_pc    = pc_w;
   assign wb_rd    = rd_w;
   assign wb_data  = data_w;

endmodule

// File: exu_bru.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_bru import exu_pkg::*; (
   input  logic                 valid_e,
   input  exu_op_t              op,
   input  logic [`EXU_XLEN-1:0] a,
   input  logic [`EXU_XLEN-1:0] b,
   input  logic [`EXU_XLEN-1:0] pc,
   input  logic [`EXU_XLEN-1:0] offs,
   output logic                 taken,
   output logic [`EXU_XLEN-1:0] target
);

   logic eq;
   logic lt_s;
   logic lt_u;
   logic cond;

   assign eq   = (a == b);
   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         OP_BEQ:  cond = eq;
         OP_BNE:  cond = ~eq;
         OP_BLT:  cond = lt_s;
         OP_BLTU: cond = lt_u;
         default: cond = 1'b0;   // not a branch
      endcase
   end

   assign taken = valid_e & cond;

   // offset counts instruction words
   assign target = pc + {offs[`EXU_XLEN-3:0], 2'b00};

endmodule

// File: exu_alu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_alu import exu_pkg::*; (
   input  logic [`EXU_XLEN-1:0] a,
   input  logic [`EXU_XLEN-1:0] b,
   input  exu_op_t              op,
   output logic [`EXU_XLEN-1:0] res
);

   localparam int SHAMT_W = $clog2(`EXU_XLEN);

   logic [`EXU_XLEN-1:0] sum;
   logic [`EXU_XLEN-1:0] diff;
   logic [SHAMT_W-1:0]   shamt;
   logic                 lt_s;
   logic                 lt_u;

   assign sum   = a + b;
   assign diff  = a - b;
   assign shamt = b[SHAMT_W-1:0];   // low bits of rk only
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;

   // immediate forms arrive with b already extended
   always_comb begin
      case (op)
         OP_ADD,
         OP_ADDI: res = sum;
         OP_SUB:  res = diff;
         OP_AND,
         OP_ANDI: res = a & b;
         OP_OR,
         OP_ORI:  res = a | b;
         OP_XOR:  res = a ^ b;
         OP_SLT:  res = {{(`EXU_XLEN-1){1'b0}}, lt_s};
         OP_SLTU: res = {{(`EXU_XLEN-1){1'b0}}, lt_u};
         OP_SLL:  res = a << shamt;
         OP_SRL:  res = a >> shamt;
         default: res = '0;   // branches, result unused
      endcase
   end

endmodule

// File: exu_regfile.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_regfile (
   input  logic                 clk,
   input  logic                 reset,

   input  logic [`EXU_RAW-1:0]  raddr0,
   input  logic [`EXU_RAW-1:0]  raddr1,
   output logic [`EXU_XLEN-1:0] rdata0,
   output logic [`EXU_XLEN-1:0] rdata1,

   input  logic                 wen,
   input  logic [`EXU_RAW-1:0]  waddr,
   input  logic [`EXU_XLEN-1:0] wdata
);

   logic [`EXU_XLEN-1:0] regs [`EXU_NREG];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `EXU_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin   // r0 stays zero
         regs[waddr] <= wdata;
      end
   end

   // async read, r0 forced to zero
   assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: exu_pkg.sv
`include "exu_macros.svh"

package exu_pkg;

   // predecoded operation, supplied alongside the raw instruction word
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_SLT  = 4'h5,
      OP_SLTU = 4'h6,
      OP_SLL  = 4'h7,
      OP_SRL  = 4'h8,
      OP_ADDI = 4'h9,
      OP_ANDI = 4'ha,
      OP_ORI  = 4'hb,
      OP_BEQ  = 4'hc,
      OP_BNE  = 4'hd,
      OP_BLT  = 4'he,
      OP_BLTU = 4'hf
   } exu_op_t;

   // one instruction word, three field layouts
   typedef union packed {
      struct packed {
         logic [16:0]         opcode;
         logic [`EXU_RAW-1:0] rk;
         logic [`EXU_RAW-1:0] rj;
         logic [`EXU_RAW-1:0] rd;
      } r3;
      struct packed {
         logic [9:0]          opcode;
         logic [11:0]         imm12;
         logic [`EXU_RAW-1:0] rj;
         logic [`EXU_RAW-1:0] rd;
      } ri12;
      struct packed {
         logic [5:0]          opcode;
         logic [15:0]         offs16;
         logic [`EXU_RAW-1:0] rj;
         logic [`EXU_RAW-1:0] rd;   // second compare source on branches
      } ri16;
   } inst_word_t;

endpackage

// File: exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath and pc width
`define EXU_XLEN 32

// general register file
`define EXU_NREG 32
`define EXU_RAW  5   // log2 of EXU_NREG

`endif
